/* run.sh */
#!/usr/bin/env bash
# build and run the amul testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module amul_tb -f sources.f -o amul_sim

# the simulator exits non-zero on failure, the log decides
./obj_dir/amul_sim > sim.log 2>&1 || true
cat sim.log
grep -qx "TEST OK" sim.log

/* sources.f */
+incdir+src
src/amul_pkg.sv
src/amul_apb_pkg.sv
src/amul_cla_adder.sv
src/amul_partial_mult.sv
src/amul_accumulator.sv
src/amul_ctrl.sv
src/amul_top.sv
test/amul_sva.sv
test/amul_tb.sv

/* src/amul_accumulator.sv */
/*
 * amul accumulator
 * aligns each tagged partial product by its quarter, adds it to the
 * running sum through the lookahead adder and holds the result.
 * In approx mode the ll quarter is dropped.
 */
`timescale 1ns/1ns
`include "amul_cfg.svh"

module amul_accumulator (
   input  logic               pclk,
   input  logic               reset,
   input  logic               acc_clear,
   input  logic               skip_ll,
   input  logic               pp_valid,
   input  amul_pkg::quarter_t pp_quarter,
   input  amul_pkg::pp_t      pp,
   output amul_pkg::product_t sum
);

   amul_pkg::product_t acc_q;
   amul_pkg::product_t aligned;
   amul_pkg::product_t addend;
   logic               add_en;

   always_comb begin
      case (pp_quarter)
         amul_pkg::q_ll: aligned = amul_pkg::product_t'(pp);
         amul_pkg::q_hh: aligned = amul_pkg::product_t'(pp) << (2 * `AMUL_BYTE_W);
         default:        aligned = amul_pkg::product_t'(pp) << `AMUL_BYTE_W; // hl, lh
      endcase
   end

   assign add_en = pp_valid & ~(skip_ll & (pp_quarter == amul_pkg::q_ll));
   assign addend = add_en ? aligned : '0; // adding zero holds the sum

   // sum is the value acc_q takes at the next edge
   amul_cla_adder #(
      .WIDTH (`AMUL_PROD_W)
   ) adder_inst (
      .x (acc_q),
      .y (addend),
      .s (sum)
   );

   always_ff @(posedge pclk) begin
      if (reset || acc_clear)
         acc_q <= '0;
      else
         acc_q <= sum;
   end

endmodule

/* src/amul_apb_pkg.sv */
/*
 * amul bus-side types
 * APB address and data words, and the bit layout of the
 * CTRL and STATUS registers
 */
`include "amul_cfg.svh"

package amul_apb_pkg;

   localparam int DATA_W = 32;

   typedef logic [`AMUL_APB_AW-1:0] apb_addr_t;
   typedef logic [DATA_W-1:0]       apb_data_t;

   // STATUS bits 1:0
   typedef struct packed {
      logic done; // bit 1
      logic busy; // bit 0
   } status_t;

   // CTRL bits 1:0
   typedef struct packed {
      logic approx; // bit 1, kept
      logic start;  // bit 0, pulse only
   } ctrl_t;

endpackage

/* src/amul_cfg.svh */
/*
 * amul configuration
 * operand, byte and product widths of the quarter multiplier,
 * APB address width and the register offsets of the bus side
 */
`ifndef AMUL_CFG_SVH
`define AMUL_CFG_SVH

`define AMUL_OP_W   16 // operand a and b
`define AMUL_BYTE_W 8  // one operand half
`define AMUL_PROD_W 32 // full product

`define AMUL_APB_AW 4

// register offsets
`define AMUL_REG_OPERAND 4'h0
`define AMUL_REG_CTRL    4'h4
`define AMUL_REG_STATUS  4'h8
`define AMUL_REG_RESULT  4'hC

`endif

/* src/amul_cla_adder.sv */
/*
 * amul block carry-lookahead adder
 * 4-bit groups with group propagate and generate, a lookahead level
 * that gives each group its carry-in, and local lookahead inside
 * each group. No carry in, no carry out. WIDTH is a multiple of 4,
 * at least 8.
 */
`timescale 1ns/1ns
`include "amul_cfg.svh"

module amul_cla_adder #(
   parameter int WIDTH = `AMUL_PROD_W
) (
   input  logic [WIDTH-1:0] x,
   input  logic [WIDTH-1:0] y,
   output logic [WIDTH-1:0] s
);

   localparam int NG = WIDTH / 4;

   logic [WIDTH-1:0] p;
   logic [WIDTH-1:0] g;
   logic [WIDTH-1:0] c;  // carry into each bit
   logic [NG-2:0]    gp; // top group feeds no carry
   logic [NG-2:0]    gg;
   logic [NG-1:0]    gc; // carry into each group

   assign p = x ^ y;
   assign g = x & y;

   for (genvar j = 0; j < NG - 1; j++) begin : grp_pg
      assign gp[j] = &p[4*j+3:4*j];
      assign gg[j] = g[4*j+3]
                   | (p[4*j+3] & g[4*j+2])
                   | (p[4*j+3] & p[4*j+2] & g[4*j+1])
                   | (p[4*j+3] & p[4*j+2] & p[4*j+1] & g[4*j]);
   end

   // second level, sum of products over all lower groups
   always_comb begin
      logic term;
      gc = '0;
      for (int j = 1; j < NG; j++) begin
         for (int k = 0; k < j; k++) begin
            term = gg[k];
            for (int m = k + 1; m < j; m++)
               term = term & gp[m];
            gc[j] = gc[j] | term;
         end
      end
   end

   for (genvar j = 0; j < NG; j++) begin : grp_local
      assign c[4*j]   = gc[j];
      assign c[4*j+1] = g[4*j] | (p[4*j] & gc[j]);
      assign c[4*j+2] = g[4*j+1] | (p[4*j+1] & g[4*j])
                      | (p[4*j+1] & p[4*j] & gc[j]);
      assign c[4*j+3] = g[4*j+2] | (p[4*j+2] & g[4*j+1])
                      | (p[4*j+2] & p[4*j+1] & g[4*j])
                      | (p[4*j+2] & p[4*j+1] & p[4*j] & gc[j]);
   end

   assign s = p ^ c;

endmodule

/* src/amul_ctrl.sv */
/*
 * amul control
 * APB slave with the OPERAND, CTRL, STATUS and RESULT registers.
 * A start runs a step counter that issues the four quarters on
 * consecutive cycles, waits for the pipeline to drain and then
 * latches the final sum into RESULT.
 */
`timescale 1ns/1ns
`include "amul_cfg.svh"

module amul_ctrl (
   input  logic                    pclk,
   input  logic                    reset,
   input  amul_apb_pkg::apb_addr_t paddr,
   input  logic                    psel,
   input  logic                    penable,
   input  logic                    pwrite,
   input  amul_apb_pkg::apb_data_t pwdata,
   output amul_apb_pkg::apb_data_t prdata,
   output logic                    pready,
   output logic                    pslverr,
   output amul_pkg::operand_t      a,
   output amul_pkg::operand_t      b,
   output logic                    issue_valid,
   output amul_pkg::quarter_t      issue_quarter,
   output logic                    acc_clear,
   output logic                    skip_ll,
   input  amul_pkg::product_t      sum
);

   localparam logic [2:0] N_ISSUE   = 3'd4; // quarters per run
   localparam logic [2:0] LAST_STEP = 3'd5; // last add lands on this step

   logic                    access;
   logic                    is_operand;
   logic                    is_ctrl;
   logic                    is_status;
   logic                    is_result;
   logic                    mapped;
   logic                    operand_we;
   logic                    ctrl_we;
   logic                    start_go;
   logic                    approx;
   logic                    busy;
   logic                    done;
   logic [2:0]              step;
   amul_pkg::product_t      result;
   amul_apb_pkg::ctrl_t     wr_ctrl;
   amul_apb_pkg::ctrl_t     rd_ctrl;
   amul_apb_pkg::status_t   rd_status;
   amul_apb_pkg::apb_data_t rd_word;

   assign access     = psel & penable;
   assign is_operand = (paddr == `AMUL_REG_OPERAND);
   assign is_ctrl    = (paddr == `AMUL_REG_CTRL);
   assign is_status  = (paddr == `AMUL_REG_STATUS);
   assign is_result  = (paddr == `AMUL_REG_RESULT);
   assign mapped     = is_operand | is_ctrl | is_status | is_result;

   assign pready  = access; // no wait states
   // unmapped, read-only target, or a write that would disturb a run
   assign pslverr = access & (~mapped | (pwrite & (is_status | is_result | busy)));

   assign operand_we = access & pwrite & is_operand & ~busy;
   assign ctrl_we    = access & pwrite & is_ctrl & ~busy;
   assign wr_ctrl    = pwdata[1:0];
   assign start_go   = ctrl_we & wr_ctrl.start;
   assign acc_clear  = start_go; // clears at the start edge

   // register file
   always_ff @(posedge pclk) begin
      if (reset) begin
         a      <= '0;
         b      <= '0;
         approx <= 1'b0;
      end else begin
         if (operand_we) begin
            a <= pwdata[`AMUL_OP_W-1:0];
            b <= pwdata[2*`AMUL_OP_W-1:`AMUL_OP_W];
         end
         if (ctrl_we) begin
            approx <= wr_ctrl.approx;
         end
      end
   end

   // step sequencer
   always_ff @(posedge pclk) begin
      if (reset) begin
         busy          <= 1'b0;
         done          <= 1'b0;
         step          <= '0;
         skip_ll       <= 1'b0;
         issue_valid   <= 1'b0;
         issue_quarter <= amul_pkg::q_ll;
         result        <= '0;
      end else if (start_go) begin
         busy    <= 1'b1;
         done    <= 1'b0;
         step    <= '0;
         skip_ll <= wr_ctrl.approx; // mode held for the whole run
      end else if (busy) begin
         step          <= step + 3'd1;
         issue_valid   <= (step < N_ISSUE);
         issue_quarter <= amul_pkg::quarter_t'(step[1:0]); // ll, hl, lh, hh
         if (step == LAST_STEP) begin
            busy   <= 1'b0;
            done   <= 1'b1;
            result <= sum; // sum already includes the hh add
         end
      end
   end

   // read data
   always_comb begin
      rd_ctrl        = '0;
      rd_ctrl.approx = approx;
      rd_status.busy = busy;
      rd_status.done = done;
      rd_word        = '0;
      if (is_operand) begin
         rd_word = {b, a};
      end else if (is_ctrl) begin
         rd_word[1:0] = rd_ctrl; // start reads 0
      end else if (is_status) begin
         rd_word[1:0] = rd_status;
      end else if (is_result) begin
         rd_word = result;
      end
   end

   assign prdata = (access & ~pwrite) ? rd_word : '0;

endmodule

/* src/amul_partial_mult.sv */
/*
 * amul shared 8x8 multiplier
 * selects the operand halves named by the quarter tag, forms their
 * exact product from shifted rows and registers it with its tag
 */
`timescale 1ns/1ns
`include "amul_cfg.svh"

module amul_partial_mult (
   input  logic               pclk,
   input  logic               reset,
   input  amul_pkg::operand_t a,
   input  amul_pkg::operand_t b,
   input  logic               issue_valid,
   input  amul_pkg::quarter_t issue_quarter,
   output logic               pp_valid,
   output amul_pkg::quarter_t pp_quarter,
   output amul_pkg::pp_t      pp
);

   amul_pkg::byte_t a_byte;
   amul_pkg::byte_t b_byte;
   amul_pkg::pp_t   prod;

   // high half of a for hl and hh, high half of b for lh and hh
   always_comb begin
      if (issue_quarter == amul_pkg::q_hl || issue_quarter == amul_pkg::q_hh)
         a_byte = a[`AMUL_OP_W-1:`AMUL_BYTE_W];
      else
         a_byte = a[`AMUL_BYTE_W-1:0];
      if (issue_quarter == amul_pkg::q_lh || issue_quarter == amul_pkg::q_hh)
         b_byte = b[`AMUL_OP_W-1:`AMUL_BYTE_W];
      else
         b_byte = b[`AMUL_BYTE_W-1:0];
   end

   // one row of a per set bit of b
   always_comb begin
      prod = '0;
      for (int i = 0; i < `AMUL_BYTE_W; i++) begin
         if (b_byte[i])
            prod = prod + (amul_pkg::pp_t'(a_byte) << i);
      end
   end

   always_ff @(posedge pclk) begin
      if (reset)
         pp_valid <= 1'b0;
      else
         pp_valid <= issue_valid;
   end

   always_ff @(posedge pclk) begin
      if (issue_valid) begin
         pp         <= prod;
         pp_quarter <= issue_quarter; // tag travels with the product
      end
   end

endmodule

/* src/amul_pkg.sv */
/*
 * amul datapath types
 * operands, operand halves, 8x8 partial products, the 32-bit
 * result and the tag that names which quarter is in flight
 */
`include "amul_cfg.svh"

package amul_pkg;

   typedef logic [`AMUL_OP_W-1:0]     operand_t;
   typedef logic [`AMUL_BYTE_W-1:0]   byte_t;
   typedef logic [2*`AMUL_BYTE_W-1:0] pp_t;      // byte x byte
   typedef logic [`AMUL_PROD_W-1:0]   product_t;

   // first letter is the half of a, second the half of b
   typedef enum logic [1:0] {
      q_ll = 2'd0, // aligned at 0
      q_hl = 2'd1, // aligned at 8
      q_lh = 2'd2, // aligned at 8
      q_hh = 2'd3  // aligned at 16
   } quarter_t;

endpackage

/* src/amul_top.sv */
/*
 * amul top level
 * APB multiplier peripheral: control and register file, the shared
 * 8x8 quarter multiplier and the lookahead accumulator
 */
`timescale 1ns/1ns

module amul_top (
   input  logic                    pclk,
   input  logic                    reset,
   input  amul_apb_pkg::apb_addr_t paddr,
   input  logic                    psel,
   input  logic                    penable,
   input  logic                    pwrite,
   input  amul_apb_pkg::apb_data_t pwdata,
   output amul_apb_pkg::apb_data_t prdata,
   output logic                    pready,
   output logic                    pslverr
);

   amul_pkg::operand_t a;
   amul_pkg::operand_t b;
   logic               issue_valid;
   amul_pkg::quarter_t issue_quarter;
   logic               acc_clear;
   logic               skip_ll;
   logic               pp_valid;
   amul_pkg::quarter_t pp_quarter;
   amul_pkg::pp_t      pp;
   amul_pkg::product_t sum;

   amul_ctrl ctrl_inst (
      .pclk          (pclk),
      .reset         (reset),
      .paddr         (paddr),
      .psel          (psel),
      .penable       (penable),
      .pwrite        (pwrite),
      .pwdata        (pwdata),
      .prdata        (prdata),
      .pready        (pready),
      .pslverr       (pslverr),
      .a             (a),
      .b             (b),
      .issue_valid   (issue_valid),
      .issue_quarter (issue_quarter),
      .acc_clear     (acc_clear),
      .skip_ll       (skip_ll),
      .sum           (sum)
   );

   amul_partial_mult partial_mult_inst (
      .pclk          (pclk),
      .reset         (reset),
      .a             (a),
      .b             (b),
      .issue_valid   (issue_valid),
      .issue_quarter (issue_quarter),
      .pp_valid      (pp_valid),
      .pp_quarter    (pp_quarter),
      .pp            (pp)
   );

   amul_accumulator accumulator_inst (
      .pclk       (pclk),
      .reset      (reset),
      .acc_clear  (acc_clear),
      .skip_ll    (skip_ll),
      .pp_valid   (pp_valid),
      .pp_quarter (pp_quarter),
      .pp         (pp),
      .sum        (sum)
   );

endmodule

/* test/amul_golden.txt */
// columns: operand a, operand b, approx bit, expected product (all hex)
// approx 1 drops the product of the low bytes
0000 0000 0 00000000
0001 0001 0 00000001
FFFF FFFF 0 FFFE0001
FFFF 0001 0 0000FFFF
0000 FFFF 0 00000000
00FF 00FF 0 0000FE01
FF00 FF00 0 FE010000
0100 0100 0 00010000
1234 5678 0 06260060
8000 0002 0 00010000
ABCD 0001 0 0000ABCD
FFFF FFFF 1 FFFD0200
00FF 00FF 1 00000000
1234 5678 1 0625E800
FF00 FF00 1 FE010000
0001 0001 1 00000000
0101 0101 1 00010200
ABCD 0001 1 0000AB00
0000 0000 1 00000000

/* test/amul_sva.sv */
/*
 * amul bus and sequencing assertions
 * APB response rules and the busy, done and issue relations,
 * bound into the control block
 */
`timescale 1ns/1ns

module amul_sva (
   input logic pclk,
   input logic reset,
   input logic psel,
   input logic penable,
   input logic pready,
   input logic pslverr,
   input logic issue_valid,
   input logic busy,
   input logic done
);

   a_pready_access: assert property (@(posedge pclk) disable iff (reset)
      (psel && penable) |-> pready)
      else $error("pready low in an access cycle");

   // error response only in the access cycle
   a_pslverr_idle: assert property (@(posedge pclk) disable iff (reset)
      !(psel && penable) |-> !pslverr)
      else $error("pslverr high outside an access cycle");

   a_issue_busy: assert property (@(posedge pclk) disable iff (reset)
      issue_valid |-> busy)
      else $error("quarter issued while idle");

   a_done_busy: assert property (@(posedge pclk) disable iff (reset)
      !(done && busy))
      else $error("done and busy both high");

endmodule

bind amul_ctrl amul_sva sva_inst (
   .pclk        (pclk),
   .reset       (reset),
   .psel        (psel),
   .penable     (penable),
   .pready      (pready),
   .pslverr     (pslverr),
   .issue_valid (issue_valid),
   .busy        (busy),
   .done        (done)
);

/* test/amul_tb.sv */
/*
 * amul testbench
 * drives the APB multiplier through reset, register access, error
 * responses, the golden vectors and random pairs, and checks every
 * result against a x b or its approximation
 */
`timescale 1ns/1ns
`include "amul_cfg.svh"

module amul_tb;

   localparam int    CLK_PERIOD = 40;
   localparam int    DRIVE_DLY  = 2;  // after the rising edge
   localparam int    N_RAND     = 50;
   localparam int    RUN_CYCLES = 20; // budget per product run
   localparam [31:0] SEED       = 32'h26072c0c;

   logic                    pclk;
   logic                    reset;
   amul_apb_pkg::apb_addr_t paddr;
   logic                    psel;
   logic                    penable;
   logic                    pwrite;
   amul_apb_pkg::apb_data_t pwdata;
   amul_apb_pkg::apb_data_t prdata;
   logic                    pready;
   logic                    pslverr;
   int                      budget_cycles = 0;

   amul_pkg::operand_t q_a[$];
   amul_pkg::operand_t q_b[$];
   logic               q_ap[$];
   amul_pkg::product_t q_exp[$];

   amul_top amul_top_inst (
      .pclk    (pclk),
      .reset   (reset),
      .paddr   (paddr),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .pready  (pready),
      .pslverr (pslverr)
   );

   initial begin
      pclk = 1'b0;
      forever #(CLK_PERIOD / 2) pclk = ~pclk;
   end

   task automatic stop_run();
      $display("TEST FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_product(input string what, input amul_pkg::product_t exp,
                                input amul_pkg::product_t act);
      if (act !== exp) begin
         $display("[ERROR] %0t ns %s: expected %h, got %h", $time, what, exp, act);
         stop_run();
      end
   endtask

   task automatic check_status(input string what, input amul_apb_pkg::status_t exp,
                               input amul_apb_pkg::status_t act);
      if (act !== exp) begin
         $display("[ERROR] %0t ns %s: expected done,busy %b, got %b", $time, what, exp, act);
         stop_run();
      end
   endtask

   task automatic check_resp(input string what, input logic exp, input logic act);
      if (act !== exp) begin
         $display("[ERROR] %0t ns %s: expected pslverr %b, got %b", $time, what, exp, act);
         stop_run();
      end
   endtask

   // no wait states, so pready is high in every access cycle
   task automatic check_ready(input string what, input logic act);
      if (act !== 1'b1) begin
         $display("[ERROR] %0t ns %s: expected pready 1, got %b", $time, what, act);
         stop_run();
      end
   endtask

   task automatic check_word(input string what, input amul_apb_pkg::apb_data_t exp,
                             input amul_apb_pkg::apb_data_t act);
      if (act !== exp) begin
         $display("[ERROR] %0t ns %s: expected %h, got %h", $time, what, exp, act);
         stop_run();
      end
   endtask

   function automatic amul_apb_pkg::status_t make_status(input logic busy, input logic done);
      amul_apb_pkg::status_t st;
      st.busy = busy;
      st.done = done;
      return st;
   endfunction

   // full product, less the low x low bytes in approx mode
   function automatic amul_pkg::product_t expected_product(input amul_pkg::operand_t a,
                                                           input amul_pkg::operand_t b,
                                                           input logic approx);
      amul_pkg::product_t full;
      amul_pkg::product_t low;
      full = amul_pkg::product_t'(a) * amul_pkg::product_t'(b);
      low  = amul_pkg::product_t'(a[`AMUL_BYTE_W-1:0])
           * amul_pkg::product_t'(b[`AMUL_BYTE_W-1:0]);
      return approx ? full - low : full;
   endfunction

   // setup, access, then back to idle
   task automatic apb_xfer(input logic wr, input amul_apb_pkg::apb_addr_t addr,
                           input amul_apb_pkg::apb_data_t wdata,
                           output amul_apb_pkg::apb_data_t rdata, output logic err);
      @(posedge pclk);
      #DRIVE_DLY;
      psel    = 1'b1;
      penable = 1'b0;
      pwrite  = wr;
      paddr   = addr;
      pwdata  = wdata;
      @(posedge pclk);
      #DRIVE_DLY;
      penable = 1'b1;
      @(negedge pclk); // outputs settled mid access
      rdata = prdata;
      err   = pslverr;
      check_ready("pready in access cycle", pready);
      @(posedge pclk);
      #DRIVE_DLY;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic write_reg(input amul_apb_pkg::apb_addr_t addr,
                            input amul_apb_pkg::apb_data_t data, input logic exp_err);
      amul_apb_pkg::apb_data_t unused;
      logic                    err;
      apb_xfer(1'b1, addr, data, unused, err);
      check_resp("write response", exp_err, err);
   endtask

   task automatic read_reg(input amul_apb_pkg::apb_addr_t addr,
                           output amul_apb_pkg::apb_data_t data);
      logic err;
      apb_xfer(1'b0, addr, '0, data, err);
      check_resp("read response", 1'b0, err);
   endtask

   task automatic wait_done();
      amul_apb_pkg::apb_data_t word;
      amul_apb_pkg::status_t   st;
      st = '0;
      while (!st.done) begin
         read_reg(`AMUL_REG_STATUS, word);
         st = word[1:0];
      end
      check_status("status at end of run", make_status(1'b0, 1'b1), st);
   endtask

   task automatic run_mult(input amul_pkg::operand_t a, input amul_pkg::operand_t b,
                           input logic approx, output amul_pkg::product_t res);
      amul_apb_pkg::apb_data_t word;
      write_reg(`AMUL_REG_OPERAND, {b, a}, 1'b0);
      write_reg(`AMUL_REG_CTRL, {30'd0, approx, 1'b1}, 1'b0);
      read_reg(`AMUL_REG_STATUS, word);
      check_status("status after start", make_status(1'b1, 1'b0), word[1:0]);
      wait_done();
      read_reg(`AMUL_REG_RESULT, word);
      res = word;
   endtask

   task automatic load_golden();
      int    fd;
      string line;
      amul_pkg::operand_t va;
      amul_pkg::operand_t vb;
      logic               vap;
      amul_pkg::product_t vexp;
      fd = $fopen("test/amul_golden.txt", "r");
      if (fd == 0) begin
         $display("could not open the golden vector file test/amul_golden.txt");
         stop_run();
      end else begin
         while ($fgets(line, fd) != 0) begin
            if ($sscanf(line, "%h %h %h %h", va, vb, vap, vexp) == 4) begin // comments fail here
               q_a.push_back(va);
               q_b.push_back(vb);
               q_ap.push_back(vap);
               q_exp.push_back(vexp);
            end
         end
         $fclose(fd);
      end
   endtask

   // watchdog
   initial begin
      wait (budget_cycles > 0);
      repeat (budget_cycles) @(posedge pclk);
      $display("watchdog expired after %0d cycles, the run hung", budget_cycles);
      stop_run();
   end

   initial begin
      amul_apb_pkg::apb_data_t word;
      amul_pkg::product_t      res;
      logic                    err;
      logic [31:0]             r;
      reset   = 1'b1;
      paddr   = '0;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
      pwdata  = '0;
      void'($urandom(SEED));
      load_golden();
      if (q_a.size() == 0) begin
         $display("the golden vector file holds no vectors");
         stop_run();
      end
      budget_cycles = (q_a.size() + N_RAND) * RUN_CYCLES;
      repeat (3) @(posedge pclk);
      #DRIVE_DLY;
      reset = 1'b0;

      read_reg(`AMUL_REG_STATUS, word);
      check_status("status after reset", make_status(1'b0, 1'b0), word[1:0]);
      read_reg(`AMUL_REG_RESULT, word);
      check_product("result after reset", '0, word);

      // register readback
      write_reg(`AMUL_REG_OPERAND, 32'h5678_1234, 1'b0);
      read_reg(`AMUL_REG_OPERAND, word);
      check_word("operand readback", 32'h5678_1234, word);
      write_reg(`AMUL_REG_CTRL, 32'h2, 1'b0); // approx only
      read_reg(`AMUL_REG_CTRL, word);
      check_word("ctrl readback", 32'h2, word);

      // start, then a write while busy is rejected
      write_reg(`AMUL_REG_CTRL, 32'h3, 1'b0);
      write_reg(`AMUL_REG_OPERAND, 32'hFFFF_FFFF, 1'b1);
      read_reg(`AMUL_REG_STATUS, word);
      check_status("status while busy", make_status(1'b1, 1'b0), word[1:0]);
      wait_done();
      read_reg(`AMUL_REG_RESULT, word);
      check_product("result after rejected write", 32'h0625_E800, word);
      read_reg(`AMUL_REG_OPERAND, word);
      check_word("operand kept while busy", 32'h5678_1234, word);
      read_reg(`AMUL_REG_CTRL, word);
      check_word("start reads as zero", 32'h2, word);

      // error responses
      apb_xfer(1'b0, 4'h2, '0, word, err);
      check_resp("read of unmapped address", 1'b1, err);
      write_reg(4'h2, 32'h1, 1'b1);
      write_reg(`AMUL_REG_RESULT, 32'h1, 1'b1);
      write_reg(`AMUL_REG_STATUS, 32'h1, 1'b1);

      foreach (q_a[i]) begin
         run_mult(q_a[i], q_b[i], q_ap[i], res);
         check_product($sformatf("golden vector %0d", i), q_exp[i], res);
      end

      for (int i = 0; i < N_RAND; i++) begin
         r = $urandom;
         run_mult(r[15:0], r[31:16], i[0], res);
         check_product($sformatf("random pair %0d", i),
                       expected_product(r[15:0], r[31:16], i[0]), res);
      end

      $display("TEST OK");
      $finish;
   end

endmodule
